// ==== spectrum_display.f ====
verilog/video_pkg.sv
verilog/spectrum_pkg.sv
verilog/raster_timing.sv
verilog/bin_frame_store.sv
verilog/palette_regs.sv
verilog/pixel_compose.sv
verilog/spectrum_display_top.sv
dv/spectrum_display_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the spectrum display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module spectrum_display_tb \
    -f spectrum_display.f \
    --Mdir obj_dir -o spectrum_display_sim

out="$(./obj_dir/spectrum_display_sim)"
echo "$out"

if echo "$out" | grep -qxF ">>> PASS"; then
    exit 0
fi
exit 1

// ==== dv/spectrum_tests.txt ====
# P index color | W x y code | C x y expected_color (x, y, index, code decimal; colors hex)
# F ends a group: writes, then checks in scan order of the frame after the next vsync fall
# cleared store shows black
C 0 0 000
C 320 240 000
C 639 479 000
F
# palette load, one pixel per code, corners and blanking
P 1 f00
P 2 0f0
P 3 00f
P 4 ff0
P 5 0ff
P 6 f0f
P 7 fff
P 0 123
W 0 0 1
W 100 10 2
W 101 10 3
W 200 50 4
W 300 100 5
W 400 200 6
W 639 479 7
C 0 0 f00
C 1 0 000
C 700 5 000
C 100 10 0f0
C 101 10 00f
C 200 50 ff0
C 300 100 0ff
C 400 200 f0f
C 639 479 fff
C 0 480 000
C 320 485 000
F
# palette change only, written pixels recolor
P 1 08f
P 7 a5a
C 0 0 08f
C 100 10 0f0
C 639 479 a5a
F
# overwrite two pixels
W 100 10 5
W 0 0 0
C 0 0 000
C 100 10 0ff
C 101 10 00f
F

// ==== dv/spectrum_display_tb.sv ====
`timescale 1ns/1ps

module spectrum_display_tb;

    // 640x480 at 60 Hz, 800 x 525 total
    localparam int line_cycles  = 800;
    localparam int frame_cycles = 420000;
    // output vsync fall (0, 490) to (0, 0) of the next frame
    localparam int lead_cycles  = 35 * 800;

    // one test file entry, palette index rides in x
    typedef struct packed {
        logic        is_pal;
        logic [9:0]  x;
        logic [9:0]  y;
        logic [11:0] value;
    } op_t;

    logic                             video_clk;
    logic                             rst_n;
    logic                             store_wr_valid;
    spectrum_pkg::store_wr_t          store_wr;
    logic                             pal_wr_valid;
    spectrum_pkg::palette_wr_t        pal_wr;
    logic                             store_wr_ready;
    logic [spectrum_pkg::color_w-1:0] video_out;
    logic                             hsync;
    logic                             vsync;

    int  cyc;
    int  errors;
    int  timeouts;
    int  checks_run;
    // current group, flushed on F
    op_t writes [$];
    op_t checks [$];

    spectrum_display_top dut (
        .video_clk      (video_clk),
        .rst_n          (rst_n),
        .store_wr_valid (store_wr_valid),
        .store_wr       (store_wr),
        .pal_wr_valid   (pal_wr_valid),
        .pal_wr         (pal_wr),
        .store_wr_ready (store_wr_ready),
        .video_out      (video_out),
        .hsync          (hsync),
        .vsync          (vsync)
    );

    // 20 ns period
    always #10 video_clk = ~video_clk;

    ////////////////////////////////////////
    // basic helpers
    ////////////////////////////////////////

    // one clock, inputs and samples 1 ns past the edge
    task automatic step();
        @(posedge video_clk);
        #1;
        cyc++;
    endtask

    task automatic check_eq(input int got, input int exp, input string what);
        checks_run++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic flag_timeout(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            timeouts++;
            $display("timeout: %s", what);
        end
    endtask

    // which 0 is hsync, 1 is vsync
    task automatic wait_sync(input logic which, input logic level, input int limit,
                             output logic ok);
        int n;
        n = 0;
        while (((which ? vsync : hsync) != level) && (n < limit)) begin
            step();
            n++;
        end
        ok = ((which ? vsync : hsync) == level);
    endtask

    // high first, so a fall already in progress is skipped
    task automatic wait_vsync_fall();
        logic ok;
        wait_sync(1'b1, 1'b1, frame_cycles, ok);
        if (ok) begin
            wait_sync(1'b1, 1'b0, frame_cycles, ok);
        end
        flag_timeout(ok, "vsync never fell within a frame");
    endtask

    ////////////////////////////////////////
    // sync timing, measured on the outputs
    ////////////////////////////////////////

    task automatic check_sync_timing();
        int   t0;
        int   t1;
        logic ok;
        wait_vsync_fall();
        t0 = cyc;
        wait_sync(1'b0, 1'b0, line_cycles, ok);
        flag_timeout(ok, "hsync never went low after the vsync fall");
        t1 = cyc;
        // first hsync of line 490 at x = 656
        check_eq(t1 - t0, 656, "hsync fall after vsync fall");
        wait_sync(1'b0, 1'b1, line_cycles, ok);
        flag_timeout(ok, "hsync never went high again");
        check_eq(cyc - t1, 96, "hsync low width");
        wait_sync(1'b0, 1'b0, line_cycles, ok);
        flag_timeout(ok, "hsync never fell on the next line");
        check_eq(cyc - t1, line_cycles, "hsync period");
        wait_sync(1'b1, 1'b1, frame_cycles, ok);
        flag_timeout(ok, "vsync never went high again");
        check_eq(cyc - t0, 2 * line_cycles, "vsync low width");
        wait_vsync_fall();
        check_eq(cyc - t0, frame_cycles, "vsync period");
    endtask

    ////////////////////////////////////////
    // test file groups
    ////////////////////////////////////////

    task automatic apply_write(input op_t op);
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        if (op.is_pal) begin
            // single cycle strobe, never refused
            pal_wr_valid = 1'b1;
            pal_wr.index = spectrum_pkg::bin_code_t'(op.x[2:0]);
            pal_wr.color = op.value;
            step();
            pal_wr_valid = 1'b0;
        end else begin
            store_wr_valid = 1'b1;
            store_wr.addr  = video_pkg::addr_w'(int'(op.y) * 640 + int'(op.x));
            store_wr.code  = spectrum_pkg::bin_code_t'(op.value[2:0]);
            // held until an edge with ready high
            while (!taken && (n < 100)) begin
                taken = store_wr_ready;
                step();
                n++;
            end
            store_wr_valid = 1'b0;
            flag_timeout(taken, "a pixel write was never accepted");
        end
    endtask

    // all codes white, so any stale code left by the clear would show
    task automatic preload_palette();
        op_t op;
        op        = '0;
        op.is_pal = 1'b1;
        op.value  = 12'hfff;
        for (int i = 1; i <= spectrum_pkg::palette_size; i++) begin
            op.x = 10'(i);
            apply_write(op);
        end
    endtask

    task automatic run_group();
        int done;
        int target;
        done = 0;
        while (!store_wr_ready && (done < frame_cycles)) begin
            step();
            done++;
        end
        flag_timeout(store_wr_ready, "store_wr_ready never came up for a group");
        foreach (writes[i]) begin
            apply_write(writes[i]);
        end
        wait_vsync_fall();
        // cycles counted from the fall, (0, 490) of this frame
        done = 0;
        foreach (checks[i]) begin
            target = lead_cycles + int'(checks[i].y) * line_cycles + int'(checks[i].x);
            assert (target >= done) else begin
                errors++;
                $display("check at (%0d, %0d) is out of scan order", checks[i].x, checks[i].y);
            end
            while (done < target) begin
                step();
                done++;
            end
            checks_run++;
            assert (video_out == checks[i].value) else begin
                errors++;
                $display("ERR %0t: pixel (%0d, %0d) expected %03h got %03h", $time,
                         checks[i].x, checks[i].y, checks[i].value, video_out);
            end
        end
        writes.delete();
        checks.delete();
    endtask

    task automatic parse_line(input string line);
        op_t op;
        byte kind;
        int  a;
        int  b;
        int  c;
        int  n;
        a    = 0;
        b    = 0;
        c    = 0;
        kind = line.getc(0);
        case (kind)
            // index and color, two fields
            "P": n = $sscanf(line, "P %d %h", a, c) + 1;
            "W": n = $sscanf(line, "W %d %d %d", a, b, c);
            "C": n = $sscanf(line, "C %d %d %h", a, b, c);
            default: n = 0;
        endcase
        op.is_pal = (kind == "P");
        op.x      = 10'(a);
        op.y      = 10'(b);
        op.value  = 12'(c);
        if (kind == "F") begin
            run_group();
        end else if ((kind == "P") || (kind == "W") || (kind == "C")) begin
            assert (n == 3) else begin
                errors++;
                $display("a test file line could not be read: %s", line);
            end
            if ((n == 3) && (kind == "C")) begin
                checks.push_back(op);
            end else if (n == 3) begin
                writes.push_back(op);
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int    fd;
        int    n;
        string line;
        video_clk      = 1'b0;
        rst_n          = 1'b0;
        store_wr_valid = 1'b0;
        store_wr       = '0;
        pal_wr_valid   = 1'b0;
        pal_wr         = '0;
        cyc            = 0;
        errors         = 0;
        timeouts       = 0;
        checks_run     = 0;
        repeat (10) step();
        // idle outputs while still in reset
        check_eq(hsync, 1, "hsync in reset");
        check_eq(vsync, 1, "vsync in reset");
        check_eq(video_out, 0, "video_out in reset");
        check_eq(store_wr_ready, 0, "store_wr_ready in reset");
        rst_n = 1'b1;
        // clear takes one cycle per pixel
        n = 0;
        while (!store_wr_ready && (n < frame_cycles)) begin
            step();
            n++;
        end
        flag_timeout(store_wr_ready, "store_wr_ready never rose after reset");
        check_eq(n, 640 * 480, "clear length in cycles");
        check_sync_timing();
        // first group expects black from the cleared store
        preload_palette();
        fd = $fopen("dv/spectrum_tests.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("the test file dv/spectrum_tests.txt could not be opened");
        end
        while ((fd != 0) && !$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                parse_line(line);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks_run, errors, timeouts);
        if ((errors == 0) && (timeouts == 0) && (checks_run > 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/spectrum_display_top.sv ====
`timescale 1ns/1ps

module spectrum_display_top (
    input  logic                              video_clk,
    input  logic                              rst_n,
    input  logic                              store_wr_valid,
    input  spectrum_pkg::store_wr_t           store_wr,
    input  logic                              pal_wr_valid,
    input  spectrum_pkg::palette_wr_t         pal_wr,
    output logic                              store_wr_ready,
    output logic [spectrum_pkg::color_w-1:0]  video_out,
    output logic                              hsync,
    output logic                              vsync
);

    // shared raster, fans out to all three blocks
    video_pkg::raster_t               raster;
    // code for the pixel one cycle behind raster
    spectrum_pkg::bin_code_t          rd_code;
    logic [spectrum_pkg::color_w-1:0] active_colors [spectrum_pkg::palette_size];

    ////////////////////////////////////////
    // timing
    ////////////////////////////////////////

    raster_timing u_raster_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .raster    (raster)
    );

    ////////////////////////////////////////
    // codes and colors, side by side
    ////////////////////////////////////////

    bin_frame_store u_bin_frame_store (
        .video_clk      (video_clk),
        .rst_n          (rst_n),
        .raster         (raster),
        .store_wr_valid (store_wr_valid),
        .store_wr       (store_wr),
        .store_wr_ready (store_wr_ready),
        .rd_code        (rd_code)
    );

    palette_regs u_palette_regs (
        .video_clk     (video_clk),
        .rst_n         (rst_n),
        .raster        (raster),
        .pal_wr_valid  (pal_wr_valid),
        .pal_wr        (pal_wr),
        .active_colors (active_colors)
    );

    // 2 cycles behind raster
    pixel_compose u_pixel_compose (
        .video_clk     (video_clk),
        .rst_n         (rst_n),
        .raster        (raster),
        .rd_code       (rd_code),
        .active_colors (active_colors),
        .video_out     (video_out),
        .hsync         (hsync),
        .vsync         (vsync)
    );

endmodule

// ==== verilog/pixel_compose.sv ====
`timescale 1ns/1ps

module pixel_compose (
    input  logic                              video_clk,
    input  logic                              rst_n,
    input  video_pkg::raster_t                raster,
    input  spectrum_pkg::bin_code_t           rd_code,
    input  logic [spectrum_pkg::color_w-1:0]  active_colors [spectrum_pkg::palette_size],
    output logic [spectrum_pkg::color_w-1:0]  video_out,
    output logic                              hsync,
    output logic                              vsync
);

    ////////////////////////////////////////
    // stage 1, match the store read latency
    ////////////////////////////////////////

    logic             active_q;
    video_pkg::sync_t sync_q;

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            active_q     <= 1'b0;
            sync_q.hsync <= 1'b1;
            sync_q.vsync <= 1'b1;
        end else begin
            active_q <= raster.active;
            sync_q   <= raster.sync;
        end
    end

    ////////////////////////////////////////
    // color lookup
    ////////////////////////////////////////

    logic [spectrum_pkg::color_w-1:0] color;

    always_comb begin
        // black in blanking and for code 0
        color = spectrum_pkg::color_black;
        if (active_q) begin
            for (int i = 0; i < spectrum_pkg::palette_size; i++) begin
                if (rd_code == spectrum_pkg::bin_code_t'(i + 1)) begin
                    color = active_colors[i];
                end
            end
        end
    end

    // stage 2, color and syncs leave together
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            video_out <= '0;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
        end else begin
            video_out <= color;
            hsync     <= sync_q.hsync;
            vsync     <= sync_q.vsync;
        end
    end

endmodule

// ==== verilog/palette_regs.sv ====
`timescale 1ns/1ps

module palette_regs (
    input  logic                              video_clk,
    input  logic                              rst_n,
    input  video_pkg::raster_t                raster,
    input  logic                              pal_wr_valid,
    input  spectrum_pkg::palette_wr_t         pal_wr,
    output logic [spectrum_pkg::color_w-1:0]  active_colors [spectrum_pkg::palette_size]
);

    ////////////////////////////////////////
    // pending bank, written any time
    ////////////////////////////////////////

    // entry i holds the color of code i + 1
    logic [spectrum_pkg::color_w-1:0] pending [spectrum_pkg::palette_size];

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < spectrum_pkg::palette_size; i++) begin
                pending[i] <= spectrum_pkg::color_black;
            end
        end else if (pal_wr_valid) begin
            // index bin_none matches no entry
            for (int i = 0; i < spectrum_pkg::palette_size; i++) begin
                if (pal_wr.index == spectrum_pkg::bin_code_t'(i + 1)) begin
                    pending[i] <= pal_wr.color;
                end
            end
        end
    end

    ////////////////////////////////////////
    // active bank, frame-start swap
    ////////////////////////////////////////

    // copy sees pending from before a same-cycle write
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < spectrum_pkg::palette_size; i++) begin
                active_colors[i] <= spectrum_pkg::color_black;
            end
        end else if (raster.frame_start) begin
            for (int i = 0; i < spectrum_pkg::palette_size; i++) begin
                active_colors[i] <= pending[i];
            end
        end
    end

endmodule

// ==== verilog/bin_frame_store.sv ====
`timescale 1ns/1ps

module bin_frame_store (
    input  logic                        video_clk,
    input  logic                        rst_n,
    input  video_pkg::raster_t          raster,
    input  logic                        store_wr_valid,
    input  spectrum_pkg::store_wr_t     store_wr,
    output logic                        store_wr_ready,
    output spectrum_pkg::bin_code_t     rd_code
);

    // one code per visible pixel
    spectrum_pkg::bin_code_t mem [spectrum_pkg::store_depth];

    ////////////////////////////////////////
    // clear sequencer
    ////////////////////////////////////////

    spectrum_pkg::store_state_t    state;
    logic [video_pkg::addr_w-1:0]  clr_addr;
    logic                          clr_last;

    assign clr_last = (clr_addr == video_pkg::addr_w'(spectrum_pkg::store_depth - 1));

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            state    <= spectrum_pkg::st_clear;
            clr_addr <= '0;
        end else begin
            case (state)
                spectrum_pkg::st_clear: begin
                    // one location per cycle
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_last) begin
                        state <= spectrum_pkg::st_run;
                    end
                end
                default: begin
                    // stays here until the next reset
                    state <= spectrum_pkg::st_run;
                end
            endcase
        end
    end

    // producer held off for the whole clear
    assign store_wr_ready = (state == spectrum_pkg::st_run);

    ////////////////////////////////////////
    // write port, shared by clear and producer
    ////////////////////////////////////////

    logic                          wr_en;
    logic [video_pkg::addr_w-1:0]  wr_addr;
    spectrum_pkg::bin_code_t       wr_code;

    always_comb begin
        if (state == spectrum_pkg::st_clear) begin
            wr_en   = 1'b1;
            wr_addr = clr_addr;
            wr_code = spectrum_pkg::bin_none;
        end else begin
            // accepted handshake
            wr_en   = store_wr_valid;
            wr_addr = store_wr.addr;
            wr_code = store_wr.code;
        end
    end

    always_ff @(posedge video_clk) begin
        // addresses past the last pixel are dropped
        if (wr_en && (wr_addr < video_pkg::addr_w'(spectrum_pkg::store_depth))) begin
            mem[wr_addr] <= wr_code;
        end
    end

    ////////////////////////////////////////
    // read port, one cycle latency
    ////////////////////////////////////////

    always_ff @(posedge video_clk) begin
        // bin_none while clearing or in blanking
        if (store_wr_ready && raster.active) begin
            rd_code <= mem[raster.addr];
        end else begin
            rd_code <= spectrum_pkg::bin_none;
        end
    end

endmodule

// ==== verilog/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing (
    input  logic               video_clk,
    input  logic               rst_n,
    output video_pkg::raster_t raster
);

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    logic [video_pkg::count_w-1:0] h_cnt;
    logic [video_pkg::count_w-1:0] v_cnt;
    logic                          h_wrap;
    logic                          frame_end;
    // counters just wrapped to (0, 0)
    logic                          wrap_q;

    assign h_wrap    = (h_cnt == video_pkg::count_w'(video_pkg::h_total - 1));
    assign frame_end = h_wrap && (v_cnt == video_pkg::count_w'(video_pkg::v_total - 1));

    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            h_cnt  <= '0;
            v_cnt  <= '0;
            wrap_q <= 1'b0;
        end else begin
            wrap_q <= frame_end;
            if (h_wrap) begin
                h_cnt <= '0;
                // vertical steps once per line
                if (frame_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // decode of current position
    ////////////////////////////////////////

    logic                          h_vis;
    logic                          v_vis;
    logic                          hsync_n;
    logic                          vsync_n;
    logic [video_pkg::addr_w-1:0]  lin_addr;

    assign h_vis = (h_cnt < video_pkg::count_w'(video_pkg::h_active));
    assign v_vis = (v_cnt < video_pkg::count_w'(video_pkg::v_active));

    // low inside the sync window
    assign hsync_n = !((h_cnt >= video_pkg::count_w'(video_pkg::h_sync_start)) &&
                       (h_cnt <  video_pkg::count_w'(video_pkg::h_sync_end)));
    assign vsync_n = !((v_cnt >= video_pkg::count_w'(video_pkg::v_sync_start)) &&
                       (v_cnt <  video_pkg::count_w'(video_pkg::v_sync_end)));

    // x + y * 640, garbage outside the visible area
    assign lin_addr = video_pkg::addr_w'(v_cnt) * video_pkg::addr_w'(video_pkg::h_active)
                    + video_pkg::addr_w'(h_cnt);

    // raster trails the counters by one cycle
    always_ff @(posedge video_clk) begin
        if (!rst_n) begin
            raster.addr        <= '0;
            raster.active      <= 1'b0;
            raster.frame_start <= 1'b0;
            raster.sync.hsync  <= 1'b1;
            raster.sync.vsync  <= 1'b1;
        end else begin
            raster.addr        <= lin_addr;
            raster.active      <= h_vis && v_vis;
            // no pulse for the (0, 0) right after reset
            raster.frame_start <= wrap_q;
            raster.sync.hsync  <= hsync_n;
            raster.sync.vsync  <= vsync_n;
        end
    end

endmodule

// ==== verilog/spectrum_pkg.sv ====
package spectrum_pkg;

    ////////////////////////////////////////
    // bin codes and colors
    ////////////////////////////////////////

    // code per pixel, bin_none always shows black
    typedef enum logic [2:0] {
        bin_none = 3'd0,
        bin_1    = 3'd1,
        bin_2    = 3'd2,
        bin_3    = 3'd3,
        bin_4    = 3'd4,
        bin_5    = 3'd5,
        bin_6    = 3'd6,
        bin_7    = 3'd7
    } bin_code_t;

    // 4 bits each of r, g, b
    localparam int color_w = 12;
    // codes 1..7, code 0 has no entry
    localparam int palette_size = 7;

    localparam logic [color_w-1:0] color_black = '0;

    // one code per visible pixel
    localparam int store_depth = video_pkg::h_active * video_pkg::v_active;

    ////////////////////////////////////////
    // write ports
    ////////////////////////////////////////

    // producer pixel write
    typedef struct packed {
        logic [video_pkg::addr_w-1:0] addr;
        bin_code_t                    code;
    } store_wr_t;

    // palette entry write, index bin_none is dropped
    typedef struct packed {
        bin_code_t            index;
        logic [color_w-1:0]   color;
    } palette_wr_t;

    // frame store sequencer
    typedef enum logic {
        st_clear,
        st_run
    } store_state_t;

endpackage

// ==== verilog/video_pkg.sv ====
package video_pkg;

    ////////////////////////////////////////
    // horizontal timing, in pixels
    ////////////////////////////////////////

    // visible width
    localparam int h_active     = 640;
    // first pixel with hsync low
    localparam int h_sync_start = 656;
    // hsync back high from here
    localparam int h_sync_end   = 752;
    // full line incl. porches
    localparam int h_total      = 800;

    ////////////////////////////////////////
    // vertical timing, in lines
    ////////////////////////////////////////

    localparam int v_active     = 480;
    // first line with vsync low
    localparam int v_sync_start = 490;
    localparam int v_sync_end   = 492;
    localparam int v_total      = 525;

    // counter and frame store address widths
    localparam int count_w = 10;
    localparam int addr_w  = 19;

    // both active low
    typedef struct packed {
        logic hsync;
        logic vsync;
    } sync_t;

    // one raster position, as seen by the downstream blocks
    typedef struct packed {
        // x + y * h_active, only valid while active
        logic [addr_w-1:0] addr;
        logic              active;
        // one cycle at pixel 0 of line 0
        logic              frame_start;
        sync_t             sync;
    } raster_t;

endpackage
